//--- emesh_gen_top.f
+incdir+rtl
rtl/emesh_pkg.sv
rtl/txn_gen.sv
rtl/packet_fifo.sv
rtl/mem_endpoint.sv
rtl/emesh_gen_top.sv
test/tb_emesh_gen_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the emesh_gen_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_emesh_gen_top

verilator --binary --timing --assert \
   --top-module "$TOP" \
   -f emesh_gen_top.f \
   -o sim_"$TOP"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
   echo "no result line found in $LOG"
   exit 1
fi
exit 0

//--- test/tb_emesh_gen_top.sv
`timescale 1ns/1ps
`include "emesh_macros.svh"

module tb_emesh_gen_top;

   import emesh_pkg::*;

   localparam int          COUNT      = 8;
   localparam logic [11:0] DST_ID     = 12'h081;
   localparam logic [11:0] SRC_ID     = 12'h0a3;
   localparam int          MAX_CYCLES = 2000;   // ~4x eight runs under 50% stall

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 start;
   txn_op_t              write;
   logic                 stall;
   logic                 done;
   logic                 rd_access;
   logic [`EMESH_DW-1:0] rd_data;
   logic [`EMESH_AW-1:0] rd_addr;

   integer               seed = 32'h400329db;
   logic                 stall_en;          // random stall on/off
   logic                 read_seen;         // a read run has been started
   int                   err_count = 0;
   int                   test_count = 0;
   int                   fail_tests = 0;
   int                   test_err_base;
   int                   cycle_cnt = 0;
   int                   resp_at_done;

   logic [`EMESH_DW-1:0] resp_data [$];     // captured responses
   logic [`EMESH_AW-1:0] resp_addr [$];
   logic [`EMESH_DW-1:0] model_mem [`MEM_WORDS];
   logic [`EMESH_DW-1:0] data_count;        // generator data, never reset by start

   emesh_gen_top #(.SRC_ID(SRC_ID), .DST_ID(DST_ID), .COUNT(COUNT)) DUT
   (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .write     (write),
      .stall     (stall),
      .done      (done),
      .rd_access (rd_access),
      .rd_data   (rd_data),
      .rd_addr   (rd_addr)
   );

   always #4 clk = ~clk;   // 8 ns period

   // random stall, one bit per cycle
   always @(posedge clk)
   begin
      logic [31:0] r;
      r = $random(seed);
      stall <= stall_en ? r[0] : 1'b0;
   end

   // response monitor, sees pre-edge values
   always @(posedge clk)
   begin
      if (!reset && rd_access)
      begin
         resp_data.push_back(rd_data);
         resp_addr.push_back(rd_addr);
      end
   end

   // cycle limit
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Result: FAILED");
         $finish;
      end
   end

   // a started run drops done on the next edge
   a_done_low_in_run : assert property
      (@(posedge clk) disable iff (reset) start |=> !done)
      else
      begin
         err_count++;
         $display("done stayed high after a start");
      end

   // done holds until the next start
   a_done_holds : assert property
      (@(posedge clk) disable iff (reset) (done && !start) |=> done)
      else
      begin
         err_count++;
         $display("done dropped without a start");
      end

   // no response before any read run
   a_no_early_rd : assert property
      (@(posedge clk) disable iff (reset) rd_access |-> read_seen)
      else
      begin
         err_count++;
         $display("read response seen before any read run");
      end

   task automatic begin_test();
      test_err_base = err_count;
      resp_data.delete();
      resp_addr.delete();
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (err_count == test_err_base)
         $display("test %s: passed", name);
      else
      begin
         fail_tests++;
         $display("test %s: %0d errors", name, err_count - test_err_base);
      end
   endtask

   // one start pulse, wait for done, update the model
   task automatic run_txn(input txn_op_t op);
      @(posedge clk);
      write <= op;
      start <= 1'b1;
      if (op == op_read)
         read_seen <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      do
         @(negedge clk);
      while (!done);
      resp_at_done = resp_data.size();
      if (op == op_write)
      begin
         for (int k = 0; k < COUNT; k++)
            model_mem[k] = (data_count + k) & `EMESH_ADDR_MASK;
      end
      data_count = data_count + COUNT;   // reads step data too
   endtask

   // collect a read run's responses and compare with the model
   task automatic check_reads(input string name);
      logic [`EMESH_AW-1:0] exp_addr;
      while (resp_data.size() < COUNT)
         @(negedge clk);
      repeat (4) @(negedge clk);         // any extra response would show here
      assert (resp_data.size() == COUNT)
      else
      begin
         err_count++;
         $display("FAIL %s response count expected %0d actual %0d",
                  name, COUNT, resp_data.size());
      end
      for (int i = 0; i < COUNT; i++)
      begin
         exp_addr = ((32'(DST_ID) << `EMESH_ID_SHIFT) + 32'(4 * i)) & `EMESH_ADDR_MASK;
         assert (resp_data[i] == model_mem[i])
         else
         begin
            err_count++;
            $display("FAIL %s data[%0d] expected %h actual %h",
                     name, i, model_mem[i], resp_data[i]);
         end
         assert (resp_addr[i] == exp_addr)
         else
         begin
            err_count++;
            $display("FAIL %s addr[%0d] expected %h actual %h",
                     name, i, exp_addr, resp_addr[i]);
         end
      end
   endtask

   initial
   begin
      reset      = 1'b1;
      start      = 1'b0;
      write      = op_read;
      stall      = 1'b0;
      stall_en   = 1'b0;
      read_seen  = 1'b0;
      data_count = '0;
      for (int i = 0; i < `MEM_WORDS; i++)
         model_mem[i] = '0;

      repeat (4) @(posedge clk);
      reset <= 1'b0;

      // reset state, and quiet outputs for a while
      begin_test();
      @(negedge clk);
      assert (!done && !rd_access)
      else
      begin
         err_count++;
         $display("done or rd_access high after reset");
      end
      repeat (10) @(negedge clk);
      assert (resp_data.size() == 0)
      else
      begin
         err_count++;
         $display("responses appeared with no run started");
      end
      end_test("reset");

      // plain write then read
      begin_test();
      run_txn(op_write);
      run_txn(op_read);
      check_reads("write_read");
      end_test("write_read");

      // same under random stall
      begin_test();
      stall_en <= 1'b1;
      run_txn(op_write);
      run_txn(op_read);
      check_reads("back_pressure");
      stall_en <= 1'b0;
      end_test("back_pressure");

      // addresses restart, data keeps counting
      begin_test();
      run_txn(op_write);
      run_txn(op_read);
      check_reads("restart");
      end_test("restart");

      // done timing against the response stream
      begin_test();
      run_txn(op_write);
      run_txn(op_read);
      assert (resp_at_done < COUNT)
      else
      begin
         err_count++;
         $display("all responses arrived before done, expected some after it");
      end
      check_reads("done_behavior");
      repeat (5) @(negedge clk);
      assert (done)
      else
      begin
         err_count++;
         $display("done not held after the buffer drained");
      end
      end_test("done_behavior");

      $display("tests run %0d, tests failed %0d, errors %0d",
               test_count, fail_tests, err_count);
      if (err_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- rtl/emesh_gen_top.sv
`timescale 1ns/1ps
`include "emesh_macros.svh"

// generator -> packet buffer -> memory endpoint
module emesh_gen_top
#(
   parameter logic [11:0] SRC_ID = 12'h000,
   parameter logic [11:0] DST_ID = 12'h000,
   parameter int          COUNT  = 16
)
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  emesh_pkg::txn_op_t   write,
   input  logic                 stall,
   output logic                 done,
   output logic                 rd_access,
   output logic [`EMESH_DW-1:0] rd_data,
   output logic [`EMESH_AW-1:0] rd_addr
);

   logic                 gen_access;   // generator strobe into buffer
   logic [`EMESH_PW-1:0] gen_packet;
   logic                 buf_wait;     // early back-pressure
   logic                 buf_not_empty;
   logic [`EMESH_PW-1:0] buf_packet;   // head of buffer
   logic                 ep_pop;

   txn_gen #(.SRC_ID(SRC_ID), .DST_ID(DST_ID), .COUNT(COUNT)) u_gen
   (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .write      (write),
      .wait_in    (buf_wait),
      .done       (done),
      .access_out (gen_access),
      .packet_out (gen_packet)
   );

   packet_fifo u_fifo
   (
      .clk        (clk),
      .reset      (reset),
      .access_in  (gen_access),
      .packet_in  (gen_packet),
      .pop        (ep_pop),
      .wait_out   (buf_wait),
      .not_empty  (buf_not_empty),
      .packet_out (buf_packet)
   );

   mem_endpoint u_ep
   (
      .clk        (clk),
      .reset      (reset),
      .not_empty  (buf_not_empty),
      .packet_in  (buf_packet),
      .stall      (stall),
      .pop        (ep_pop),
      .rd_access  (rd_access),
      .rd_data    (rd_data),
      .rd_addr    (rd_addr)
   );

endmodule

//--- rtl/mem_endpoint.sv
`timescale 1ns/1ps
`include "emesh_macros.svh"

// memory endpoint
// writes land in a small word memory, reads come back on a strobe
module mem_endpoint
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 not_empty,   // buffer has a packet
   input  logic [`EMESH_PW-1:0] packet_in,
   input  logic                 stall,       // external hold-off
   output logic                 pop,
   output logic                 rd_access,   // one-cycle response strobe
   output logic [`EMESH_DW-1:0] rd_data,
   output logic [`EMESH_AW-1:0] rd_addr
);

   import emesh_pkg::*;

   localparam int IDX_W = $clog2(`MEM_WORDS);

   logic [`EMESH_DW-1:0] mem [`MEM_WORDS];
   txn_op_t              pkt_op;
   logic [`EMESH_AW-1:0] pkt_dst;
   logic [`EMESH_DW-1:0] pkt_data;
   logic [IDX_W-1:0]     word_idx;
   logic                 wr_pop;
   logic                 rd_pop;

   // take a packet whenever one is there and nobody stalls
   assign pop = not_empty && !stall;

   // unpack the fields we care about
   assign pkt_op   = txn_op_t'(packet_in[`EMESH_WRITE_BIT]);
   assign pkt_dst  = packet_in[`EMESH_DSTADDR_LSB +: `EMESH_AW];
   assign pkt_data = packet_in[`EMESH_DATA_LSB +: `EMESH_DW];
   assign word_idx = pkt_dst[2 +: IDX_W];         // byte addr to word index

   assign wr_pop = pop && (pkt_op == op_write);
   assign rd_pop = pop && (pkt_op == op_read);

   // write stored at the edge of its pop
   always_ff @(posedge clk)
   begin
      if (wr_pop)
         mem[word_idx] <= pkt_data;
   end

   // response strobe
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         rd_access <= 1'b0;
      else
         rd_access <= rd_pop;
   end

   // response payload, held between reads
   always_ff @(posedge clk)
   begin
      if (rd_pop)
      begin
         rd_data <= mem[word_idx];
         rd_addr <= pkt_dst;                      // full address echoed back
      end
   end

   // only plain word accesses, no ctrlmode, reach the endpoint
   a_word_access_only : assert property
      (@(posedge clk) disable iff (reset)
       pop |-> packet_in[`EMESH_DSTADDR_LSB-1:`EMESH_DATAMODE_LSB] ==
               {5'b0, `EMESH_DATAMODE_WORD})
      else $error("mem_endpoint popped a packet that is not a word access");

endmodule

//--- rtl/packet_fifo.sv
`timescale 1ns/1ps
`include "emesh_macros.svh"

// small packet buffer between generator and endpoint
// wait goes up one slot early to absorb the txn already in flight
module packet_fifo
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 access_in,   // push strobe
   input  logic [`EMESH_PW-1:0] packet_in,
   input  logic                 pop,
   output logic                 wait_out,
   output logic                 not_empty,
   output logic [`EMESH_PW-1:0] packet_out
);

   localparam int PTR_W = $clog2(`FIFO_DEPTH);
   localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

   logic [`EMESH_PW-1:0] mem [`FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     count;        // occupancy
   logic                 full;
   logic                 push;
   logic                 do_pop;

   assign full      = (count == CNT_W'(`FIFO_DEPTH));
   assign not_empty = (count != '0);
   assign wait_out  = (count >= CNT_W'(`FIFO_DEPTH - 1));
   assign push      = access_in && !full;     // guarded anyway
   assign do_pop    = pop && not_empty;

   // head entry, valid the cycle after its push
   assign packet_out = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= packet_in;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // both or neither
         endcase
      end
   end

   // generator must respect the early wait
   a_no_push_full : assert property
      (@(posedge clk) disable iff (reset) access_in |-> !full)
      else $error("packet_fifo push while full");

   // endpoint only pops what is there
   a_no_pop_empty : assert property
      (@(posedge clk) disable iff (reset) pop |-> not_empty)
      else $error("packet_fifo pop while empty");

endmodule

//--- rtl/txn_gen.sv
`timescale 1ns/1ps
`include "emesh_macros.svh"

// transaction generator
// issues COUNT read or write packets toward DST_ID per start pulse
module txn_gen
#(
   parameter logic [11:0] SRC_ID = 12'h000,
   parameter logic [11:0] DST_ID = 12'h000,
   parameter int          COUNT  = 16
)
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,       // pulse, honored in idle or done
   input  emesh_pkg::txn_op_t       write,       // sampled with start
   input  logic                     wait_in,     // back-pressure level from buffer
   output logic                     done,
   output logic                     access_out,
   output logic [`EMESH_PW-1:0]     packet_out
);

   import emesh_pkg::*;

   localparam int CNT_W = $clog2(COUNT + 1);

   // base addresses, node id in the top bits
   localparam logic [`EMESH_AW-1:0] DST_BASE =
      (`EMESH_AW'(DST_ID) << `EMESH_ID_SHIFT) & `EMESH_ADDR_MASK;
   localparam logic [`EMESH_AW-1:0] SRC_BASE =
      (`EMESH_AW'(SRC_ID) << `EMESH_ID_SHIFT) & `EMESH_ADDR_MASK;

   // address step follows datamode, 4 bytes per word
   localparam logic [`EMESH_AW-1:0] ADDR_STEP = `EMESH_AW'(1) << `EMESH_DATAMODE_WORD;

   gen_state_t           state;
   txn_op_t              op_reg;       // opcode latched at start
   logic [CNT_W-1:0]     txn_cnt;      // transactions issued this run
   logic [`EMESH_AW-1:0] dst_next;     // address for the next issue
   logic [`EMESH_AW-1:0] src_next;
   logic [`EMESH_DW-1:0] data_next;    // runs on across restarts
   logic                 launch;
   logic                 issue;
   logic                 last_issue;

   // registered packet fields
   logic                 pkt_write;
   logic [`EMESH_AW-1:0] pkt_dst;
   logic [`EMESH_AW-1:0] pkt_src;
   logic [`EMESH_DW-1:0] pkt_data;

   assign launch     = start && (state == gen_idle || state == gen_done);
   assign issue      = (state == gen_go) && !wait_in;   // one txn per free cycle
   assign last_issue = issue && (txn_cnt == CNT_W'(COUNT - 1));
   assign done       = (state == gen_done);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= gen_idle;
      else
      begin
         case (state)
            gen_idle, gen_done:
               if (start)
                  state <= gen_go;
            gen_go:
               if (last_issue)
                  state <= gen_done;   // exactly COUNT issued
            default:
               state <= gen_idle;
         endcase
      end
   end

   // run counters and stepping addresses
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         op_reg    <= op_read;
         txn_cnt   <= '0;
         dst_next  <= DST_BASE;
         src_next  <= SRC_BASE;
         data_next <= '0;
      end
      else if (launch)
      begin
         op_reg   <= write;
         txn_cnt  <= '0;
         dst_next <= DST_BASE;           // addresses restart, data does not
         src_next <= SRC_BASE;
      end
      else if (issue)
      begin
         txn_cnt   <= txn_cnt + 1'b1;
         dst_next  <= (dst_next + ADDR_STEP) & `EMESH_ADDR_MASK;
         src_next  <= (src_next + ADDR_STEP) & `EMESH_ADDR_MASK;
         data_next <= (data_next + 1'b1) & `EMESH_ADDR_MASK;
      end
   end

   // access strobe, one cycle per issue
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         access_out <= 1'b0;
      else
         access_out <= issue;
   end

   // payload captured with the current (pre-step) values
   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         pkt_write <= op_reg;
         pkt_dst   <= dst_next;
         pkt_src   <= src_next;
         pkt_data  <= data_next;
      end
   end

   // packet packing
   assign packet_out[`EMESH_WRITE_BIT] = pkt_write;
   assign packet_out[`EMESH_CTRLMODE_LSB-1:`EMESH_DATAMODE_LSB] = `EMESH_DATAMODE_WORD;
   assign packet_out[`EMESH_DSTADDR_LSB-1:`EMESH_CTRLMODE_LSB]  = '0;   // no ctrlmode traffic
   assign packet_out[`EMESH_DSTADDR_LSB +: `EMESH_AW] = pkt_dst;
   assign packet_out[`EMESH_DATA_LSB +: `EMESH_DW]    = pkt_data;
   assign packet_out[`EMESH_SRCADDR_LSB +: `EMESH_AW] = pkt_src;

   // wait is honored one cycle ahead of the strobe
   a_no_access_after_wait : assert property
      (@(posedge clk) disable iff (reset) wait_in |=> !access_out)
      else $error("txn_gen issued access while buffer signalled wait");

endmodule

//--- rtl/emesh_pkg.sv
// shared types for the mesh traffic generator subsystem
package emesh_pkg;

   // generator control states
   typedef enum logic [1:0]
   {
      gen_idle = 2'b00,   // waiting for first start
      gen_go   = 2'b01,   // issuing transactions
      gen_done = 2'b10    // run complete, restartable
   } gen_state_t;

   // transaction opcode, doubles as the packet write bit
   typedef enum logic
   {
      op_read  = 1'b0,
      op_write = 1'b1
   } txn_op_t;

endpackage

//--- rtl/emesh_macros.svh
`ifndef EMESH_MACROS_SVH
`define EMESH_MACROS_SVH

// packet and field widths
`define EMESH_PW 104
`define EMESH_AW 32
`define EMESH_DW 32

// packet field positions, lsb of each field
`define EMESH_WRITE_BIT    0
`define EMESH_DATAMODE_LSB 1
`define EMESH_CTRLMODE_LSB 3
`define EMESH_DSTADDR_LSB  8
`define EMESH_DATA_LSB     40
`define EMESH_SRCADDR_LSB  72

`define EMESH_DATAMODE_WORD 2'b10        // 32-bit access
`define EMESH_ADDR_MASK     32'hFFF07FFF // applied after each step
`define EMESH_ID_SHIFT      20           // node id sits in addr[31:20]

`define FIFO_DEPTH 4
`define MEM_WORDS  16

`endif
